// ==== source/dd_bus_pkg.sv ====
package dd_bus_pkg;

    localparam int unsigned ADDR_W = 9;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned MASK_W = DATA_W / 8;

    // ####################
    // CPU port

    typedef struct packed {
        logic              req;    // One-cycle request strobe
        logic [ADDR_W-1:0] addr;   // Byte address, word aligned
        logic [DATA_W-1:0] wdata;
        logic [MASK_W-1:0] wmask;  // All zero for a plain read
    } cpu_req_t;

    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] rdata;
    } cpu_rsp_t;

    // ####################
    // Host port

    typedef struct packed {
        logic              req;
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } host_req_t;

    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] rdata;
    } host_rsp_t;

endpackage

// ==== source/dd_drive_pkg.sv ====
package dd_drive_pkg;

    localparam int unsigned SECTOR_WORDS  = 64;
    localparam int unsigned SECTOR_LANES  = 4;
    localparam int unsigned SECTOR_ADDR_W = 6;

    typedef enum logic [2:0] {
        R_SCR,
        R_CMD_DATA,
        R_HEAD_TRACK,
        R_SECTOR_INFO,
        R_DRIVE_ID
    } cpu_reg_e;

    typedef enum logic [2:0] {
        H_STATUS,
        H_CMD,
        H_DATA,
        H_BM_CTL,
        H_HEAD_TRACK,
        H_DRIVE_ID
    } host_reg_e;

    typedef struct packed {
        logic        hard_reset;
        logic        cmd_pending;
        logic        bm_pending;
        logic        bm_start_pending;
        logic        bm_stop_pending;
        logic        bm_transfer_mode;
        logic        bm_transfer_blocks;
        logic        bm_interrupt_ack;  // Single-cycle pulse
        logic [7:0]  cmd;
        logic [15:0] data;
    } dd_status_t;

    typedef struct packed {
        logic        hard_reset_clear;
        logic        cmd_ready;
        logic        bm_ready;
        logic        bm_start_clear;
        logic        bm_stop_clear;
        logic        bm_micro_error;
        logic        bm_transfer_c2;
        logic        bm_transfer_data;
        logic        disk_changed;
        logic        disk_inserted;
        logic [15:0] cmd_data;
        logic        index_lock;
        logic [12:0] head_track;
        logic [2:0]  drive_id;
    } dd_ctrl_t;

    typedef struct packed {
        logic                     we;
        logic [SECTOR_ADDR_W-1:0] addr;
        logic [31:0]              data;  // Stored byte-reversed
    } sector_wr_t;

    function automatic logic [31:0] swap_bytes(logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // Status/control word, same layout on both ports
    function automatic logic [31:0] scr_word(dd_status_t st, dd_ctrl_t ct, logic bm_ack);
        return {
            13'd0,
            bm_ack,                 // Bit 18
            1'b0,
            ct.bm_micro_error,
            ct.bm_transfer_c2,
            ct.bm_transfer_data,
            st.bm_transfer_blocks,
            st.bm_transfer_mode,
            1'b0,
            st.bm_stop_pending,
            1'b0,
            st.bm_start_pending,
            ct.disk_changed,
            ct.disk_inserted,
            1'b0,
            st.bm_pending,
            1'b0,
            st.cmd_pending,
            1'b0,
            st.hard_reset
        };
    endfunction

endpackage

// ==== source/dd_sector_lane.sv ====
`timescale 1ns/1ps

module dd_sector_lane #(
    parameter int unsigned LANE = 0
) (
    input  logic                                   sys,
    input  dd_drive_pkg::sector_wr_t               wr,
    input  logic [dd_drive_pkg::SECTOR_ADDR_W-1:0] cpu_raddr,
    input  logic [dd_drive_pkg::SECTOR_ADDR_W-1:0] host_raddr,
    output logic [7:0]                             cpu_rdata,
    output logic [7:0]                             host_rdata
);

    logic [7:0] mem [dd_drive_pkg::SECTOR_WORDS];

    always_ff @(posedge sys) begin
        if (wr.we) begin
            mem[wr.addr] <= wr.data[8*LANE +: 8];  // Own byte only
        end
    end

    // Read ports are independent, old data on a same-address write
    always_ff @(posedge sys) begin
        cpu_rdata  <= mem[cpu_raddr];
        host_rdata <= mem[host_raddr];
    end

endmodule

// ==== source/dd_cpu_regs.sv ====
`timescale 1ns/1ps

module dd_cpu_regs (
    input  logic                                   sys,
    input  logic                                   arst_n,
    input  dd_bus_pkg::cpu_req_t                   cpu_req,
    input  dd_drive_pkg::dd_status_t               status,
    input  logic [31:0]                            sector_rdata,
    output dd_bus_pkg::cpu_rsp_t                   cpu_rsp,
    output dd_drive_pkg::dd_ctrl_t                 ctrl,
    output dd_drive_pkg::sector_wr_t               sector_wr,
    output logic [dd_drive_pkg::SECTOR_ADDR_W-1:0] sector_raddr
);

    logic       ack;
    logic [8:0] rd_addr;
    logic       bm_ack;
    logic       reg_wr;

    assign reg_wr = cpu_req.req && !cpu_req.addr[8];

    // ####################
    // Sector buffer path

    always_comb begin
        sector_raddr   = cpu_req.addr[7:2];
        sector_wr.addr = cpu_req.addr[7:2];
        sector_wr.we   = cpu_req.req && cpu_req.addr[8] && (&cpu_req.wmask);
        sector_wr.data = dd_drive_pkg::swap_bytes(cpu_req.wdata);
    end

    // ####################
    // Register writes and clear pulses

    always_ff @(posedge sys or negedge arst_n) begin
        if (!arst_n) begin
            ack    <= 1'b0;
            bm_ack <= 1'b0;
            ctrl   <= '0;
        end else begin
            ack                   <= cpu_req.req;
            ctrl.hard_reset_clear <= 1'b0;
            ctrl.cmd_ready        <= 1'b0;
            ctrl.bm_ready         <= 1'b0;
            ctrl.bm_start_clear   <= 1'b0;
            ctrl.bm_stop_clear    <= 1'b0;

            if (reg_wr) begin
                case (dd_drive_pkg::cpu_reg_e'(cpu_req.addr[4:2]))
                    dd_drive_pkg::R_SCR: begin
                        if (&cpu_req.wmask) begin
                            if (cpu_req.wdata[18]) begin
                                bm_ack <= 1'b0;
                            end
                            ctrl.bm_micro_error   <= cpu_req.wdata[16];
                            ctrl.bm_transfer_c2   <= cpu_req.wdata[15];
                            ctrl.bm_transfer_data <= cpu_req.wdata[14];
                            ctrl.bm_stop_clear    <= cpu_req.wdata[11];
                            ctrl.bm_start_clear   <= cpu_req.wdata[9];
                            ctrl.disk_changed     <= cpu_req.wdata[7];
                            ctrl.disk_inserted    <= cpu_req.wdata[6];
                            ctrl.bm_ready         <= cpu_req.wdata[5];
                            ctrl.cmd_ready        <= cpu_req.wdata[3];
                            ctrl.hard_reset_clear <= cpu_req.wdata[1];
                        end
                    end
                    dd_drive_pkg::R_CMD_DATA: begin
                        if (&cpu_req.wmask[1:0]) begin
                            ctrl.cmd_data <= cpu_req.wdata[15:0];
                        end
                    end
                    dd_drive_pkg::R_HEAD_TRACK: begin
                        if (&cpu_req.wmask[1:0]) begin
                            {ctrl.index_lock, ctrl.head_track} <= cpu_req.wdata[13:0];
                        end
                    end
                    dd_drive_pkg::R_DRIVE_ID: begin
                        if (cpu_req.wmask[0]) begin
                            ctrl.drive_id <= cpu_req.wdata[2:0];
                        end
                    end
                    default: begin
                    end
                endcase
            end

            if (status.bm_interrupt_ack) begin
                bm_ack <= 1'b1;  // Set beats clear
            end
        end
    end

    always_ff @(posedge sys) begin
        if (cpu_req.req) begin
            rd_addr <= cpu_req.addr;
        end
    end

    // ####################
    // Readback

    always_comb begin
        cpu_rsp.ack   = ack;
        cpu_rsp.rdata = '0;
        if (ack) begin
            if (rd_addr[8]) begin
                cpu_rsp.rdata = dd_drive_pkg::swap_bytes(sector_rdata);  // Undo storage swap
            end else begin
                case (dd_drive_pkg::cpu_reg_e'(rd_addr[4:2]))
                    dd_drive_pkg::R_SCR:
                        cpu_rsp.rdata = dd_drive_pkg::scr_word(status, ctrl, bm_ack);
                    dd_drive_pkg::R_CMD_DATA:
                        cpu_rsp.rdata = {8'd0, status.cmd, status.data};
                    dd_drive_pkg::R_HEAD_TRACK:
                        cpu_rsp.rdata = {18'd0, ctrl.index_lock, ctrl.head_track};
                    dd_drive_pkg::R_SECTOR_INFO:
                        cpu_rsp.rdata = '0;  // Not emulated
                    dd_drive_pkg::R_DRIVE_ID:
                        cpu_rsp.rdata = {29'd0, ctrl.drive_id};
                    default:
                        cpu_rsp.rdata = '0;
                endcase
            end
        end
    end

endmodule

// ==== source/dd_host_port.sv ====
`timescale 1ns/1ps

module dd_host_port (
    input  logic                                   sys,
    input  logic                                   arst_n,
    input  dd_bus_pkg::host_req_t                  host_req,
    input  dd_drive_pkg::dd_ctrl_t                 ctrl,
    input  logic [31:0]                            sector_rdata,
    output dd_bus_pkg::host_rsp_t                  host_rsp,
    output dd_drive_pkg::dd_status_t               status,
    output logic [dd_drive_pkg::SECTOR_ADDR_W-1:0] sector_raddr
);

    logic       ack;
    logic [8:0] rd_addr;
    logic       reg_wr;

    assign reg_wr       = host_req.req && host_req.we && !host_req.addr[8];
    assign sector_raddr = host_req.addr[7:2];

    // ####################
    // Pending flags, CPU clears first so a host set wins

    always_ff @(posedge sys or negedge arst_n) begin
        if (!arst_n) begin
            ack    <= 1'b0;
            status <= '0;
        end else begin
            ack                     <= host_req.req;
            status.bm_interrupt_ack <= 1'b0;

            if (ctrl.hard_reset_clear) begin
                status.hard_reset <= 1'b0;
            end
            if (ctrl.cmd_ready) begin
                status.cmd_pending <= 1'b0;
            end
            if (ctrl.bm_ready) begin
                status.bm_pending <= 1'b0;
            end
            if (ctrl.bm_start_clear) begin
                status.bm_start_pending <= 1'b0;
            end
            if (ctrl.bm_stop_clear) begin
                status.bm_stop_pending <= 1'b0;
            end

            if (reg_wr) begin
                case (dd_drive_pkg::host_reg_e'(host_req.addr[4:2]))
                    dd_drive_pkg::H_STATUS: begin
                        if (host_req.wdata[0]) begin
                            status.hard_reset <= 1'b1;
                        end
                    end
                    dd_drive_pkg::H_CMD: begin
                        status.cmd         <= host_req.wdata[23:16];
                        status.data        <= host_req.wdata[15:0];
                        status.cmd_pending <= 1'b1;
                    end
                    dd_drive_pkg::H_BM_CTL: begin
                        if (host_req.wdata[0]) begin
                            status.bm_start_pending <= 1'b1;
                            status.bm_pending       <= 1'b1;
                        end
                        if (host_req.wdata[1]) begin
                            status.bm_stop_pending <= 1'b1;
                        end
                        status.bm_interrupt_ack   <= host_req.wdata[2];
                        status.bm_transfer_mode   <= host_req.wdata[3];
                        status.bm_transfer_blocks <= host_req.wdata[4];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge sys) begin
        if (host_req.req) begin
            rd_addr <= host_req.addr;
        end
    end

    // ####################
    // Readback

    always_comb begin
        host_rsp.ack   = ack;
        host_rsp.rdata = '0;
        if (ack) begin
            if (rd_addr[8]) begin
                host_rsp.rdata = sector_rdata;  // Stored order, no swap
            end else begin
                case (dd_drive_pkg::host_reg_e'(rd_addr[4:2]))
                    dd_drive_pkg::H_STATUS:
                        host_rsp.rdata = dd_drive_pkg::scr_word(status, ctrl, 1'b0);
                    dd_drive_pkg::H_CMD:
                        host_rsp.rdata = {8'd0, status.cmd, status.data};
                    dd_drive_pkg::H_DATA:
                        host_rsp.rdata = {16'd0, ctrl.cmd_data};
                    dd_drive_pkg::H_HEAD_TRACK:
                        host_rsp.rdata = {18'd0, ctrl.index_lock, ctrl.head_track};
                    dd_drive_pkg::H_DRIVE_ID:
                        host_rsp.rdata = {29'd0, ctrl.drive_id};
                    default:
                        host_rsp.rdata = '0;
                endcase
            end
        end
    end

endmodule

// ==== source/dd_ctrl_top.sv ====
`timescale 1ns/1ps

module dd_ctrl_top (
    input  logic                  sys,
    input  logic                  arst_n,
    input  dd_bus_pkg::cpu_req_t  cpu_req,
    input  dd_bus_pkg::host_req_t host_req,
    output dd_bus_pkg::cpu_rsp_t  cpu_rsp,
    output dd_bus_pkg::host_rsp_t host_rsp
);

    dd_drive_pkg::dd_status_t               status;
    dd_drive_pkg::dd_ctrl_t                 ctrl;
    dd_drive_pkg::sector_wr_t               sector_wr;
    logic [dd_drive_pkg::SECTOR_ADDR_W-1:0] cpu_raddr;
    logic [dd_drive_pkg::SECTOR_ADDR_W-1:0] host_raddr;
    logic [31:0]                            cpu_sector_rdata;
    logic [31:0]                            host_sector_rdata;

    dd_cpu_regs i_cpu_regs (
        .sys          (sys),
        .arst_n       (arst_n),
        .cpu_req      (cpu_req),
        .status       (status),
        .sector_rdata (cpu_sector_rdata),
        .cpu_rsp      (cpu_rsp),
        .ctrl         (ctrl),
        .sector_wr    (sector_wr),
        .sector_raddr (cpu_raddr)
    );

    // One memory per byte lane
    for (genvar i = 0; i < dd_drive_pkg::SECTOR_LANES; i++) begin : g_lane
        dd_sector_lane #(
            .LANE (i)
        ) i_lane (
            .sys        (sys),
            .wr         (sector_wr),
            .cpu_raddr  (cpu_raddr),
            .host_raddr (host_raddr),
            .cpu_rdata  (cpu_sector_rdata[8*i +: 8]),
            .host_rdata (host_sector_rdata[8*i +: 8])
        );
    end

    dd_host_port i_host_port (
        .sys          (sys),
        .arst_n       (arst_n),
        .host_req     (host_req),
        .ctrl         (ctrl),
        .sector_rdata (host_sector_rdata),
        .host_rsp     (host_rsp),
        .status       (status),
        .sector_raddr (host_raddr)
    );

endmodule

// ==== tests/dd_ctrl_clock.sv ====
`timescale 1ns/1ps

module dd_ctrl_clock #(
    parameter int unsigned HALF_NS      = 10,
    parameter int unsigned RESET_CYCLES = 5
) (
    output logic sys,
    output logic arst_n
);

    initial begin
        sys = 1'b0;
        forever #(HALF_NS) sys = ~sys;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge sys);
        #2 arst_n = 1'b1;  // Released off the edge
    end

endmodule

// ==== tests/dd_ctrl_tb.sv ====
`timescale 1ns/1ps

module dd_ctrl_tb;

    localparam int unsigned COLS        = 6;
    localparam int unsigned MAX_OPS     = 128;
    localparam int unsigned DRIVE_DELAY = 2;
    localparam string       VEC_FILE    = "tests/dd_ctrl_vectors.txt";

    logic                  sys;
    logic                  arst_n;
    dd_bus_pkg::cpu_req_t  cpu_req;
    dd_bus_pkg::host_req_t host_req;
    dd_bus_pkg::cpu_rsp_t  cpu_rsp;
    dd_bus_pkg::host_rsp_t host_rsp;

    logic [31:0] vec [COLS*MAX_OPS];  // COLS words per operation
    int unsigned n_ops  = 0;
    int unsigned cycles = 0;
    int unsigned limit  = 0;

    dd_ctrl_clock #(
        .HALF_NS      (10),
        .RESET_CYCLES (5)
    ) i_clock (
        .sys    (sys),
        .arst_n (arst_n)
    );

    dd_ctrl_top i_dut (
        .sys      (sys),
        .arst_n   (arst_n),
        .cpu_req  (cpu_req),
        .host_req (host_req),
        .cpu_rsp  (cpu_rsp),
        .host_rsp (host_rsp)
    );

    // ####################
    // Response checks

    task automatic check_cpu_rsp(
        input dd_bus_pkg::cpu_rsp_t got,
        input dd_bus_pkg::cpu_rsp_t exp,
        input logic                 cmp_rdata,
        input int unsigned          idx
    );
        if (got.ack !== exp.ack) begin
            if (exp.ack) begin
                $display("CPU port gave no ack one cycle after request %0d, time %0t",
                         idx, $time);
            end else begin
                $display("CPU port raised ack outside its ack cycle, request %0d, time %0t",
                         idx, $time);
            end
            $display("Simulation finished: FAIL");
            $fatal(1, "wrong ack");
        end else if (cmp_rdata && got.rdata !== exp.rdata) begin
            $display("[FAIL] %0t cpu_rsp.rdata got %08h expected %08h (vector %0d)",
                     $time, got.rdata, exp.rdata, idx);
            $display("Simulation finished: FAIL");
            $fatal(1, "read data mismatch");
        end
    endtask

    task automatic check_host_rsp(
        input dd_bus_pkg::host_rsp_t got,
        input dd_bus_pkg::host_rsp_t exp,
        input logic                  cmp_rdata,
        input int unsigned           idx
    );
        if (got.ack !== exp.ack) begin
            if (exp.ack) begin
                $display("Host port gave no ack one cycle after request %0d, time %0t",
                         idx, $time);
            end else begin
                $display("Host port raised ack outside its ack cycle, request %0d, time %0t",
                         idx, $time);
            end
            $display("Simulation finished: FAIL");
            $fatal(1, "wrong ack");
        end else if (cmp_rdata && got.rdata !== exp.rdata) begin
            $display("[FAIL] %0t host_rsp.rdata got %08h expected %08h (vector %0d)",
                     $time, got.rdata, exp.rdata, idx);
            $display("Simulation finished: FAIL");
            $fatal(1, "read data mismatch");
        end
    endtask

    // ####################
    // Vectors and bus driving

    task automatic load_vectors();
        for (int i = 0; i < COLS * MAX_OPS; i++) begin
            vec[i] = '1;  // Port field above 1 marks the end
        end
        $readmemh(VEC_FILE, vec);
        n_ops = 0;
        while (n_ops < MAX_OPS && vec[n_ops*COLS] <= 32'd1) begin
            n_ops++;
        end
    endtask

    task automatic run_op(input int unsigned idx);
        int unsigned           base;
        logic                  is_host;
        logic                  is_read;
        dd_bus_pkg::cpu_rsp_t  cpu_exp;
        dd_bus_pkg::host_rsp_t host_exp;
        dd_bus_pkg::cpu_rsp_t  cpu_idle;
        dd_bus_pkg::host_rsp_t host_idle;

        base           = idx * COLS;
        is_host        = vec[base][0];
        is_read        = !vec[base+1][0];
        cpu_exp.ack    = 1'b1;
        cpu_exp.rdata  = vec[base+5];
        host_exp.ack   = 1'b1;
        host_exp.rdata = vec[base+5];
        cpu_idle       = '0;
        host_idle      = '0;

        @(posedge sys);
        #(DRIVE_DELAY);
        if (is_host) begin
            host_req.req   = 1'b1;
            host_req.we    = !is_read;
            host_req.addr  = vec[base+2][8:0];
            host_req.wdata = vec[base+3];
        end else begin
            cpu_req.req   = 1'b1;
            cpu_req.addr  = vec[base+2][8:0];
            cpu_req.wdata = vec[base+3];
            cpu_req.wmask = vec[base+4][3:0];  // Zero on reads
        end

        @(negedge sys);  // Request cycle, no ack yet on either port
        check_cpu_rsp(cpu_rsp, cpu_idle, 1'b1, idx);
        check_host_rsp(host_rsp, host_idle, 1'b1, idx);

        @(posedge sys);
        #(DRIVE_DELAY);
        cpu_req  = '0;  // Idle cycle follows
        host_req = '0;

        @(negedge sys);  // Middle of the ack cycle
        if (is_host) begin
            check_host_rsp(host_rsp, host_exp, is_read, idx);
            check_cpu_rsp(cpu_rsp, cpu_idle, 1'b1, idx);
        end else begin
            check_cpu_rsp(cpu_rsp, cpu_exp, is_read, idx);
            check_host_rsp(host_rsp, host_idle, 1'b1, idx);
        end
    endtask

    // ####################
    // Timeout

    always @(posedge sys) begin
        cycles = cycles + 1;
        if (limit != 0 && cycles > limit) begin
            $display("Timeout, the run did not end within %0d cycles", limit);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    // ####################
    // Main sequence

    initial begin
        cpu_req  = '0;
        host_req = '0;
        load_vectors();
        if (n_ops == 0) begin
            $display("No operations could be read from %s", VEC_FILE);
            $display("Simulation finished: FAIL");
            $fatal(1, "empty vector file");
        end else begin
            limit = 4 * n_ops + 20;
            $display("Running %0d operations, cycle limit %0d", n_ops, limit);
            wait (arst_n === 1'b1);
            for (int unsigned i = 0; i < n_ops; i++) begin
                run_op(i);
            end
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

// ==== dd_ctrl.f ====
source/dd_bus_pkg.sv
source/dd_drive_pkg.sv
source/dd_sector_lane.sv
source/dd_cpu_regs.sv
source/dd_host_port.sv
source/dd_ctrl_top.sv
tests/dd_ctrl_clock.sv
tests/dd_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: dd_ctrl

sources:
  # Packages first, then RTL leaf modules and the top level
  - source/dd_bus_pkg.sv
  - source/dd_drive_pkg.sv
  - source/dd_sector_lane.sv
  - source/dd_cpu_regs.sv
  - source/dd_host_port.sv
  - source/dd_ctrl_top.sv

  # Testbench
  - target: test
    files:
      - tests/dd_ctrl_clock.sv
      - tests/dd_ctrl_tb.sv

// ==== tests/dd_ctrl_vectors.txt ====
// Columns in hex: port (0 cpu, 1 host), write, address, wdata, wmask, expected rdata
// Expected rdata is compared on reads only; wmask is unused on the host port
// After reset everything reads zero
0 0 000 00000000 0 00000000
0 0 004 00000000 0 00000000
0 0 008 00000000 0 00000000
0 0 010 00000000 0 00000000
1 0 000 00000000 0 00000000
// Host command, seen by the CPU, acknowledged with SCR bit 3
1 1 004 00a51234 0 00000000
0 0 000 00000000 0 00000004
0 0 004 00000000 0 00a51234
0 1 000 00000008 f 00000000
1 0 000 00000000 0 00000000
// Hard reset set by the host, cleared with SCR bit 1
1 1 000 00000001 0 00000000
0 0 000 00000000 0 00000001
0 1 000 00000002 f 00000000
1 0 000 00000000 0 00000000
// Block transfer start, stop, mode and blocks
1 1 00c 00000019 0 00000000
0 0 000 00000000 0 00003110
1 1 00c 0000001a 0 00000000
1 0 000 00000000 0 00003510
// Partial wmask on SCR has no effect
0 1 000 00000a20 7 00000000
1 0 000 00000000 0 00003510
0 1 000 00000200 f 00000000
0 0 000 00000000 0 00003410
0 1 000 00000820 f 00000000
1 0 000 00000000 0 00003000
// Interrupt acknowledge sets sticky bit 18 on the CPU side only
1 1 00c 0000001c 0 00000000
0 0 000 00000000 0 00043000
1 0 000 00000000 0 00003000
0 1 000 00040000 3 00000000
0 0 000 00000000 0 00043000
0 1 000 00040000 f 00000000
0 0 000 00000000 0 00003000
// CPU level bits show on both ports
0 1 000 0001c0c0 f 00000000
1 0 000 00000000 0 0001f0c0
0 0 000 00000000 0 0001f0c0
// CPU registers read back by the host
0 1 004 0000beef 3 00000000
1 0 008 00000000 0 0000beef
0 1 004 00001111 1 00000000
1 0 008 00000000 0 0000beef
0 1 008 ffffffff 3 00000000
1 0 010 00000000 0 00003fff
0 0 008 00000000 0 00003fff
0 1 010 fffffffd 1 00000000
1 0 014 00000000 0 00000005
0 0 010 00000000 0 00000005
0 0 004 00000000 0 00a51234
// Sector buffer, host sees the stored byte order
0 1 104 12345678 f 00000000
0 0 104 00000000 0 12345678
1 0 104 00000000 0 78563412
0 1 104 aaaaaaaa 7 00000000
0 0 104 00000000 0 12345678
1 0 104 00000000 0 78563412
0 1 1fc deadbeef f 00000000
1 0 1fc 00000000 0 efbeadde
0 0 1fc 00000000 0 deadbeef
0 0 104 00000000 0 12345678
